// File: logic/qbank_pkg.sv
`default_nettype none

package qbank_pkg;

    // Bus and field widths
    typedef logic [31:0] wb_data_t;
    typedef logic [11:0] wb_adr_t;
    typedef logic [3:0]  chan_t;
    typedef logic [5:0]  offset_t;
    typedef logic [6:0]  count_t;

    // Operation code in address bits 1:0
    typedef enum logic [1:0] {
        OP_PUSH   = 2'd0,
        OP_POP    = 2'd1,
        OP_PEEK   = 2'd2,
        OP_STATUS = 2'd3
    } queue_op_t;

    // Per-channel command, strobes last one cycle
    typedef struct packed {
        logic     push;
        logic     pop;
        logic     clear_ovf;
        offset_t  offset;
        wb_data_t data;
    } chan_cmd_t;

    // Per-channel status, sits in the low bits of the status word
    typedef struct packed {
        count_t count;
        logic   empty;
        logic   full;
        logic   almost_empty;
        logic   almost_full;
        logic   overflow;
    } chan_status_t;

    // Response selection, held through the ack cycle
    typedef struct packed {
        queue_op_t op;
        chan_t     channel;
        logic      valid_chan;
    } resp_sel_t;

endpackage

`default_nettype wire

// File: logic/chan_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module chan_fifo #(
    parameter int ADDR_WIDTH             = 3,
    parameter int ALMOST_FULL_THRESHOLD  = 2,
    parameter int ALMOST_EMPTY_THRESHOLD = 2
) (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire qbank_pkg::chan_cmd_t    cmd,
    output qbank_pkg::wb_data_t          rd_data,
    output qbank_pkg::wb_data_t          peek_data,
    output qbank_pkg::chan_status_t      status
);

    localparam int DEPTH = 1 << ADDR_WIDTH;
    localparam qbank_pkg::count_t DEPTH_COUNT = qbank_pkg::count_t'(DEPTH);
    localparam qbank_pkg::count_t AF_LEVEL =
        qbank_pkg::count_t'(DEPTH - ALMOST_FULL_THRESHOLD);
    localparam qbank_pkg::count_t AE_LEVEL =
        qbank_pkg::count_t'(ALMOST_EMPTY_THRESHOLD);

    qbank_pkg::wb_data_t mem [DEPTH];

    // Pointers carry one extra wrap bit
    logic [ADDR_WIDTH:0]   wr_ptr;
    logic [ADDR_WIDTH:0]   rd_ptr;
    logic [ADDR_WIDTH:0]   ptr_diff;
    logic [ADDR_WIDTH-1:0] peek_addr;
    qbank_pkg::count_t     count;
    logic                  empty;
    logic                  full;
    logic                  do_push;
    logic                  do_pop;
    logic                  peek_hit;
    logic                  overflow;

    assign ptr_diff = wr_ptr - rd_ptr;
    assign count    = qbank_pkg::count_t'(ptr_diff);
    assign empty    = (count == '0);
    assign full     = (count == DEPTH_COUNT);

    // A full channel drops the word
    assign do_push = cmd.push && !full;
    assign do_pop  = cmd.pop && !empty;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
        end else if (do_push) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr <= '0;
        end else if (do_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr[ADDR_WIDTH-1:0]] <= cmd.data;
        end
    end

    // Pop on empty keeps the last popped word
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_data <= '0;
        end else if (do_pop) begin
            rd_data <= mem[rd_ptr[ADDR_WIDTH-1:0]];
        end
    end

    // Sticky overflow; a fresh overflow beats a clear in the same cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            overflow <= 1'b0;
        end else if (cmd.push && full) begin
            overflow <= 1'b1;
        end else if (cmd.clear_ovf) begin
            overflow <= 1'b0;
        end
    end

    // Peek relative to the oldest entry, zero past the count
    assign peek_addr = rd_ptr[ADDR_WIDTH-1:0] + cmd.offset[ADDR_WIDTH-1:0];
    assign peek_hit  = ({1'b0, cmd.offset} < count);
    assign peek_data = peek_hit ? mem[peek_addr] : '0;

    always_comb begin
        status.count        = count;
        status.empty        = empty;
        status.full         = full;
        status.almost_empty = (count <= AE_LEVEL) && !empty;
        status.almost_full  = (count >= AF_LEVEL) && !full;
        status.overflow     = overflow;
    end

    // Pointer difference must stay within the buffer
    a_count_bound: assert property (
        @(posedge clk) disable iff (!rst_n)
        count <= DEPTH_COUNT
    ) else $error("chan_fifo count %0d above depth", count);

endmodule

`default_nettype wire

// File: logic/wb_queue_port.sv
`timescale 1ns/10ps
`default_nettype none

module wb_queue_port #(
    parameter int NUM_CHANNELS = 4
) (
    input  wire                                     clk,
    input  wire                                     rst_n,
    input  wire                                     wb_cyc,
    input  wire                                     wb_stb,
    input  wire                                     wb_we,
    input  wire qbank_pkg::wb_adr_t                 wb_adr,
    input  wire qbank_pkg::wb_data_t                wb_dat_w,
    output logic                                    wb_ack,
    output qbank_pkg::chan_cmd_t [NUM_CHANNELS-1:0] cmd,
    output qbank_pkg::resp_sel_t                    resp_sel
);

    qbank_pkg::queue_op_t op;
    qbank_pkg::chan_t     chan;
    qbank_pkg::offset_t   offset;
    logic                 access;
    logic                 chan_ok;

    // First cycle of a request, before ack goes out
    assign access = wb_cyc && wb_stb && !wb_ack;

    // Address fields: offset, channel, operation
    assign op      = qbank_pkg::queue_op_t'(wb_adr[1:0]);
    assign chan    = wb_adr[5:2];
    assign offset  = wb_adr[11:6];
    assign chan_ok = (int'(chan) < NUM_CHANNELS);

    // Only the addressed channel sees a strobe
    always_comb begin
        for (int i = 0; i < NUM_CHANNELS; i++) begin
            cmd[i].push      = 1'b0;
            cmd[i].pop       = 1'b0;
            cmd[i].clear_ovf = 1'b0;
            cmd[i].offset    = offset;
            cmd[i].data      = wb_dat_w;
            if (access && (chan == qbank_pkg::chan_t'(i))) begin
                cmd[i].push      = wb_we && (op == qbank_pkg::OP_PUSH);
                cmd[i].pop       = !wb_we && (op == qbank_pkg::OP_POP);
                cmd[i].clear_ovf = !wb_we && (op == qbank_pkg::OP_STATUS);
            end
        end
    end

    // Single-cycle registered ack
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= access;
        end
    end

    // Remember what the ack cycle has to return
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            resp_sel.op         <= qbank_pkg::OP_PUSH;
            resp_sel.channel    <= '0;
            resp_sel.valid_chan <= 1'b0;
        end else if (access) begin
            resp_sel.op         <= op;
            resp_sel.channel    <= chan;
            resp_sel.valid_chan <= chan_ok;
        end
    end

    // Ack only while the master still holds the request
    a_ack_in_cycle: assert property (
        @(posedge clk) disable iff (!rst_n)
        wb_ack |-> (wb_cyc && wb_stb)
    ) else $error("wb_ack without cyc and stb");

endmodule

`default_nettype wire

// File: logic/queue_readback.sv
`timescale 1ns/10ps
`default_nettype none

module queue_readback #(
    parameter int NUM_CHANNELS = 4
) (
    input  wire                                           clk,
    input  wire                                           rst_n,
    input  wire qbank_pkg::resp_sel_t                     resp_sel,
    input  wire qbank_pkg::wb_data_t [NUM_CHANNELS-1:0]   rd_data,
    input  wire qbank_pkg::wb_data_t [NUM_CHANNELS-1:0]   peek_data,
    input  wire qbank_pkg::chan_status_t [NUM_CHANNELS-1:0] status,
    input  wire                                           peek_req,
    output qbank_pkg::wb_data_t                           wb_dat_r,
    output logic                                          irq
);

    qbank_pkg::wb_data_t [NUM_CHANNELS-1:0]     peek_q;
    qbank_pkg::chan_status_t [NUM_CHANNELS-1:0] status_q;
    qbank_pkg::wb_data_t                        pop_word;
    qbank_pkg::wb_data_t                        peek_word;
    qbank_pkg::wb_data_t                        status_word;
    logic                                       irq_any;

    // Snapshot every channel on the access edge, so status is pre-edge
    always_ff @(posedge clk) begin
        if (peek_req) begin
            peek_q   <= peek_data;
            status_q <= status;
        end
    end

    // Pick the addressed channel; stays zero for an invalid channel
    always_comb begin
        pop_word    = '0;
        peek_word   = '0;
        status_word = '0;
        for (int i = 0; i < NUM_CHANNELS; i++) begin
            if (resp_sel.valid_chan && (resp_sel.channel == qbank_pkg::chan_t'(i))) begin
                pop_word    = rd_data[i];
                peek_word   = peek_q[i];
                status_word = qbank_pkg::wb_data_t'(status_q[i]);
            end
        end
    end

    always_comb begin
        case (resp_sel.op)
            qbank_pkg::OP_POP:    wb_dat_r = pop_word;
            qbank_pkg::OP_PEEK:   wb_dat_r = peek_word;
            qbank_pkg::OP_STATUS: wb_dat_r = status_word;
            default:              wb_dat_r = '0;
        endcase
    end

    // Any channel near full, full or overflowed
    always_comb begin
        irq_any = 1'b0;
        for (int i = 0; i < NUM_CHANNELS; i++) begin
            irq_any |= status[i].almost_full | status[i].full | status[i].overflow;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            irq <= 1'b0;
        end else begin
            irq <= irq_any;
        end
    end

endmodule

`default_nettype wire

// File: logic/queue_bank.sv
`timescale 1ns/10ps
`default_nettype none

module queue_bank #(
    parameter int NUM_CHANNELS           = 4,
    parameter int ADDR_WIDTH             = 3,
    parameter int ALMOST_FULL_THRESHOLD  = 2,
    parameter int ALMOST_EMPTY_THRESHOLD = 2
) (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire                      wb_cyc,
    input  wire                      wb_stb,
    input  wire                      wb_we,
    input  wire qbank_pkg::wb_adr_t  wb_adr,
    input  wire qbank_pkg::wb_data_t wb_dat_w,
    output qbank_pkg::wb_data_t      wb_dat_r,
    output logic                     wb_ack,
    output logic                     irq
);

    qbank_pkg::chan_cmd_t [NUM_CHANNELS-1:0]    cmd;
    qbank_pkg::wb_data_t [NUM_CHANNELS-1:0]     rd_data;
    qbank_pkg::wb_data_t [NUM_CHANNELS-1:0]     peek_data;
    qbank_pkg::chan_status_t [NUM_CHANNELS-1:0] status;
    qbank_pkg::resp_sel_t                       resp_sel;
    wire                                        peek_req;

    // Access cycle as seen by the port
    assign peek_req = wb_cyc && wb_stb && !wb_ack;

    wb_queue_port #(
        .NUM_CHANNELS (NUM_CHANNELS)
    ) u_port (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_ack   (wb_ack),
        .cmd      (cmd),
        .resp_sel (resp_sel)
    );

    for (genvar g = 0; g < NUM_CHANNELS; g++) begin : g_chan
        chan_fifo #(
            .ADDR_WIDTH             (ADDR_WIDTH),
            .ALMOST_FULL_THRESHOLD  (ALMOST_FULL_THRESHOLD),
            .ALMOST_EMPTY_THRESHOLD (ALMOST_EMPTY_THRESHOLD)
        ) u_fifo (
            .clk       (clk),
            .rst_n     (rst_n),
            .cmd       (cmd[g]),
            .rd_data   (rd_data[g]),
            .peek_data (peek_data[g]),
            .status    (status[g])
        );
    end

    queue_readback #(
        .NUM_CHANNELS (NUM_CHANNELS)
    ) u_readback (
        .clk       (clk),
        .rst_n     (rst_n),
        .resp_sel  (resp_sel),
        .rd_data   (rd_data),
        .peek_data (peek_data),
        .status    (status),
        .peek_req  (peek_req),
        .wb_dat_r  (wb_dat_r),
        .irq       (irq)
    );

endmodule

`default_nettype wire

// File: tests/queue_bank_model.svh
`ifndef QUEUE_BANK_MODEL_SVH
`define QUEUE_BANK_MODEL_SVH

// Reference queues, oldest word at index 0
qbank_pkg::wb_data_t model_q [NUM_CHANNELS][$];
logic                model_ovf [NUM_CHANNELS];
logic [31:0]         lcg_state;

function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
endfunction

function automatic int rand_below(input int n);
    logic [31:0] r;
    r = next_rand();
    return int'(r[31:8]) % n;
endfunction

// Count, empty, full, almost empty, almost full, overflow
function automatic qbank_pkg::wb_data_t model_status(input int ch);
    int n;
    n = model_q[ch].size();
    return {20'd0, 7'(n), (n == 0), (n == DEPTH), ((n > 0) && (n <= AE_THR)),
            ((n >= DEPTH - AF_THR) && (n < DEPTH)), model_ovf[ch]};
endfunction

// Near full, full or overflowed on any channel
function automatic logic model_irq();
    logic any_hit;
    any_hit = 1'b0;
    for (int c = 0; c < NUM_CHANNELS; c++) begin
        if ((model_q[c].size() >= DEPTH - AF_THR) || model_ovf[c]) begin
            any_hit = 1'b1;
        end
    end
    return any_hit;
endfunction

// One classic cycle; irq is sampled once the access has settled
task automatic bus_access(input logic we, input qbank_pkg::wb_adr_t adr,
                          input qbank_pkg::wb_data_t wdata,
                          output qbank_pkg::wb_data_t rdata, output logic irq_seen);
    int waited;
    waited = 0;
    rdata  = '0;
    @(posedge clk);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= we;
    wb_adr   <= adr;
    wb_dat_w <= wdata;
    @(negedge clk);
    while (!wb_ack && waited < ACK_TIMEOUT) begin
        @(negedge clk);
        waited++;
    end
    if (!wb_ack) begin
        $display("ERROR at %0t: no wb_ack within %0d cycles for address %h",
                 $time, ACK_TIMEOUT, adr);
        error_count++;
    end else begin
        rdata = wb_dat_r;
    end
    @(posedge clk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
    @(negedge clk);
    irq_seen = irq;
    // Ack lasts a single cycle
    check_count++;
    if (wb_ack) begin
        $display("ERROR at %0t: wb_ack stayed high for more than one cycle", $time);
        error_count++;
    end
endtask

`endif

// File: tests/queue_bank_tb.sv
`timescale 1ns/10ps
`default_nettype none

module queue_bank_tb;

    localparam int NUM_CHANNELS = 4;
    localparam int ADDR_WIDTH   = 3;
    localparam int DEPTH        = 1 << ADDR_WIDTH;
    localparam int AF_THR       = 2;
    localparam int AE_THR       = 2;
    localparam int ACK_TIMEOUT  = 16;

    logic                clk = 1'b0;
    logic                rst_n;
    logic                wb_cyc;
    logic                wb_stb;
    logic                wb_we;
    qbank_pkg::wb_adr_t  wb_adr;
    qbank_pkg::wb_data_t wb_dat_w;
    qbank_pkg::wb_data_t wb_dat_r;
    logic                wb_ack;
    logic                irq;
    int                  error_count;
    int                  check_count;
    int                  test_count;
    int                  failed_tests;
    int                  test_base;

    always #10 clk = ~clk;

    queue_bank #(
        .NUM_CHANNELS           (NUM_CHANNELS),
        .ADDR_WIDTH             (ADDR_WIDTH),
        .ALMOST_FULL_THRESHOLD  (AF_THR),
        .ALMOST_EMPTY_THRESHOLD (AE_THR)
    ) UUT (.*);

    `include "queue_bank_model.svh"

    // Predict, access, then compare read data and irq
    task automatic run_op(input int ch, input qbank_pkg::queue_op_t op,
                          input qbank_pkg::wb_data_t wdata, input int offs);
        qbank_pkg::wb_data_t exp_data;
        qbank_pkg::wb_data_t got_data;
        logic                check_data;
        logic                valid;
        logic                got_irq;
        logic                exp_irq;
        valid      = (ch < NUM_CHANNELS);
        check_data = (op != qbank_pkg::OP_PUSH);
        exp_data   = '0;
        case (op)
            qbank_pkg::OP_PUSH: begin
                if (valid && model_q[ch].size() < DEPTH) begin
                    model_q[ch].push_back(wdata);
                end else if (valid) begin
                    model_ovf[ch] = 1'b1;
                end
            end
            qbank_pkg::OP_POP: begin
                // Pop on empty repeats an old word
                if (valid && model_q[ch].size() == 0) begin
                    check_data = 1'b0;
                end else if (valid) begin
                    exp_data = model_q[ch].pop_front();
                end
            end
            qbank_pkg::OP_PEEK: begin
                if (valid && offs < model_q[ch].size()) begin
                    exp_data = model_q[ch][offs];
                end
            end
            default: begin
                if (valid) begin
                    exp_data      = model_status(ch);
                    model_ovf[ch] = 1'b0;
                end
            end
        endcase
        bus_access(op == qbank_pkg::OP_PUSH, {6'(offs), 4'(ch), 2'(op)}, wdata,
                   got_data, got_irq);
        exp_irq = model_irq();
        check_count += check_data ? 2 : 1;
        if (check_data && got_data !== exp_data) begin
            $display("MISMATCH at %0t: wb_dat_r expected %h got %h (channel %0d op %0d)",
                     $time, exp_data, got_data, ch, op);
            error_count++;
        end
        if (got_irq !== exp_irq) begin
            $display("MISMATCH at %0t: irq expected %b got %b", $time, exp_irq, got_irq);
            error_count++;
        end
    endtask

    task automatic drain(input int ch);
        int n;
        n = model_q[ch].size();
        for (int k = 0; k < n; k++) begin
            run_op(ch, qbank_pkg::OP_POP, '0, 0);
        end
    endtask

    task automatic end_test(input string name);
        test_count++;
        if (error_count == test_base) begin
            $display("test %s: ok", name);
        end else begin
            failed_tests++;
            $display("test %s: %0d errors", name, error_count - test_base);
        end
        test_base = error_count;
    endtask

    initial begin
        rst_n        = 1'b0;
        wb_cyc       = 1'b0;
        wb_stb       = 1'b0;
        wb_we        = 1'b0;
        wb_adr       = '0;
        wb_dat_w     = '0;
        lcg_state    = 32'd81086;
        error_count  = 0;
        check_count  = 0;
        test_count   = 0;
        failed_tests = 0;
        test_base    = 0;
        for (int c = 0; c < NUM_CHANNELS; c++) begin
            model_ovf[c] = 1'b0;
        end
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;

        for (int c = 0; c < NUM_CHANNELS; c++) begin
            run_op(c, qbank_pkg::OP_STATUS, '0, 0);
        end
        end_test("after reset");

        for (int i = 0; i < 400; i++) begin
            if (rand_below(2) == 0) begin
                run_op(rand_below(NUM_CHANNELS), qbank_pkg::OP_PUSH, next_rand(), 0);
            end else begin
                run_op(rand_below(NUM_CHANNELS), qbank_pkg::OP_POP, '0, 0);
            end
        end
        end_test("random traffic");

        // Offsets run past the count on purpose
        for (int i = 0; i < 150; i++) begin
            if (rand_below(3) == 0) begin
                run_op(rand_below(NUM_CHANNELS), qbank_pkg::OP_PUSH, next_rand(), 0);
            end else begin
                run_op(rand_below(NUM_CHANNELS), qbank_pkg::OP_PEEK, '0, rand_below(DEPTH + 4));
            end
        end
        for (int c = 0; c < NUM_CHANNELS; c++) begin
            drain(c);
        end
        end_test("peek");

        for (int k = 0; k < DEPTH + 3; k++) begin
            run_op(2, qbank_pkg::OP_PUSH, next_rand(), 0);
        end
        run_op(2, qbank_pkg::OP_STATUS, '0, 0);
        run_op(2, qbank_pkg::OP_STATUS, '0, 0);
        drain(2);
        end_test("full channel");

        // Walk channel 1 up to full and back down
        for (int k = 0; k < DEPTH; k++) begin
            run_op(1, qbank_pkg::OP_PUSH, next_rand(), 0);
            run_op(1, qbank_pkg::OP_STATUS, '0, 0);
        end
        for (int k = 0; k < DEPTH; k++) begin
            run_op(1, qbank_pkg::OP_POP, '0, 0);
            run_op(1, qbank_pkg::OP_STATUS, '0, 0);
        end
        end_test("status flags");

        for (int k = 0; k < 3; k++) begin
            run_op(0, qbank_pkg::OP_PUSH, next_rand(), 0);
        end
        for (int i = 0; i < 60; i++) begin
            run_op(NUM_CHANNELS + rand_below(16 - NUM_CHANNELS),
                   qbank_pkg::queue_op_t'(2'(rand_below(4))), next_rand(), rand_below(DEPTH));
        end
        for (int c = 0; c < NUM_CHANNELS; c++) begin
            run_op(c, qbank_pkg::OP_STATUS, '0, 0);
        end
        drain(0);
        end_test("invalid channel");

        $display("summary: %0d tests, %0d with errors, %0d checks, %0d errors",
                 test_count, failed_tests, check_count, error_count);
        if (error_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+tests
logic/qbank_pkg.sv
logic/chan_fifo.sv
logic/wb_queue_port.sv
logic/queue_readback.sv
logic/queue_bank.sv
tests/queue_bank_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= queue_bank_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= ALL TESTS PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   list these targets"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
